// ==== Makefile ====
# Verilator build, run and lint for the CSR index generator

VERILATOR ?= verilator
TOP       ?= tb_csr_index_generator
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal
LINTFLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# The run passes only when the testbench printed its pass line
run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "TB PASSED"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

// ==== source/csr_index_generator.sv ====
// Top level of the CSR index generator; a start pulse walks one edge-list range into the request FIFO
`default_nettype none
`timescale 1ns/1ps

module csr_index_generator (
    input  logic                      ap_clk,
    input  logic                      areset_generator,
    input  logic                      start,
    input  csr_index_pkg::range_cfg_t range_cfg,
    input  csr_index_pkg::addr_cfg_t  addr_cfg,
    input  logic                      rd_en,
    output csr_index_pkg::request_t   request,
    output logic                      done
);

    import csr_index_pkg::*;

    index_t   count;
    logic     counter_load;
    logic     counter_enable;
    logic     push;
    logic     prog_full;
    request_t entry;

    // ------------------------------
    // Index generation
    // ------------------------------
    index_counter i_index_counter (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .load             (counter_load),
        .enable           (counter_enable),
        .load_value       (range_cfg.index_start),
        .stride           (range_cfg.stride),
        .count            (count)
    );

    index_gen_fsm i_index_gen_fsm (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .start            (start),
        .count            (count),
        .index_end        (range_cfg.index_end),
        .prog_full        (prog_full),
        .counter_load     (counter_load),
        .counter_enable   (counter_enable),
        .push             (push),
        .done             (done)
    );

    // ------------------------------
    // Request path
    // ------------------------------
    request_builder i_request_builder (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .push             (push),
        .count            (count),
        .addr_cfg         (addr_cfg),
        .entry            (entry)
    );

    request_fifo i_request_fifo (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .entry            (entry),
        .rd_en            (rd_en),
        .request          (request),
        .prog_full        (prog_full)
    );

endmodule : csr_index_generator

`default_nettype wire

// ==== source/csr_index_pkg.sv ====
// Shared widths, FIFO sizing and struct types for the CSR index generator and its testbench
`default_nettype none

package csr_index_pkg;

    // ------------------------------
    // Widths
    // ------------------------------
    localparam int unsigned INDEX_W = 32;
    localparam int unsigned ADDR_W  = 32;
    localparam int unsigned SHIFT_W = 5;

    // ------------------------------
    // Request FIFO sizing
    // ------------------------------
    localparam int unsigned FIFO_DEPTH       = 16;
    // Half depth leaves room for pushes still in the builder when generation pauses
    localparam int unsigned FIFO_PROG_THRESH = 8;
    localparam int unsigned FIFO_COUNT_W     = 5;

    // ------------------------------
    // Scalar types
    // ------------------------------
    typedef logic [INDEX_W-1:0] index_t;
    typedef logic [ADDR_W-1:0]  addr_t;

    // ------------------------------
    // Configuration
    // ------------------------------

    // Edge-list range of one job, end is exclusive
    typedef struct packed {
        index_t index_start;
        index_t index_end;
        index_t stride;
    } range_cfg_t;

    // How an index turns into a memory offset
    typedef struct packed {
        addr_t              base;
        logic [SHIFT_W-1:0] shift_amount;
        logic               shift_left;
    } addr_cfg_t;

    // ------------------------------
    // Memory request
    // ------------------------------
    typedef struct packed {
        addr_t  base;
        addr_t  offset;
        index_t index;
    } request_payload_t;

    typedef struct packed {
        logic             valid;
        request_payload_t payload;
    } request_t;

endpackage : csr_index_pkg

`default_nettype wire

// ==== source/index_counter.sv ====
// Strided index counter, loaded with the range start and stepped once per generated request
`default_nettype none
`timescale 1ns/1ps

module index_counter (
    input  logic                  ap_clk,
    input  logic                  areset_generator,
    input  logic                  load,
    input  logic                  enable,
    input  csr_index_pkg::index_t load_value,
    input  csr_index_pkg::index_t stride,
    output csr_index_pkg::index_t count
);

    import csr_index_pkg::*;

    index_t count_q;

    // Load wins over enable so a new job always starts clean
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            count_q <= '0;
        end
        else if (load) begin
            count_q <= load_value;
        end
        else if (enable) begin
            // Increment only, wraps silently at the top of the range
            count_q <= count_q + stride;
        end
    end

    assign count = count_q;

endmodule : index_counter

`default_nettype wire

// ==== source/index_gen_fsm.sv ====
// Job sequencer: loads the counter, pushes requests while in range, pauses on FIFO back-pressure
`default_nettype none
`timescale 1ns/1ps

module index_gen_fsm (
    input  logic                  ap_clk,
    input  logic                  areset_generator,
    input  logic                  start,
    input  csr_index_pkg::index_t count,
    input  csr_index_pkg::index_t index_end,
    input  logic                  prog_full,
    output logic                  counter_load,
    output logic                  counter_enable,
    output logic                  push,
    output logic                  done
);

    import csr_index_pkg::*;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_LOAD,
        ST_BUSY,
        ST_PAUSE,
        ST_DONE
    } state_t;

    state_t state;
    state_t next_state;
    logic   in_range;
    logic   gen_ok;

    // Unsigned compare, the end index is exclusive
    assign in_range = (count < index_end);
    // A push is allowed only when there is range left and FIFO room
    assign gen_ok   = in_range & ~prog_full;

    // ------------------------------
    // State register
    // ------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            state <= ST_IDLE;
        end
        else begin
            state <= next_state;
        end
    end

    // ------------------------------
    // Next state
    // ------------------------------
    always_comb begin
        next_state = state;
        case (state)
            ST_IDLE: begin
                if (start) begin
                    next_state = ST_LOAD;
                end
            end
            ST_LOAD: begin
                next_state = ST_BUSY;
            end
            ST_BUSY: begin
                if (!in_range) begin
                    next_state = ST_DONE;
                end
                else if (prog_full) begin
                    next_state = ST_PAUSE;
                end
            end
            ST_PAUSE: begin
                // Resume once the consumer has drained below the threshold
                if (!prog_full) begin
                    next_state = ST_BUSY;
                end
            end
            ST_DONE: begin
                next_state = ST_IDLE;
            end
            default: begin
                next_state = ST_IDLE;
            end
        endcase
    end

    // ------------------------------
    // Output decode
    // ------------------------------
    assign counter_load   = (state == ST_LOAD);
    // Counter steps on the same edge the builder samples the index
    assign push           = (state == ST_BUSY) & gen_ok;
    assign counter_enable = push;
    assign done           = (state == ST_DONE);

endmodule : index_gen_fsm

`default_nettype wire

// ==== source/request_builder.sv ====
// Registers one memory request per push, with the configured base and the shifted index as offset
`default_nettype none
`timescale 1ns/1ps

module request_builder (
    input  logic                     ap_clk,
    input  logic                     areset_generator,
    input  logic                     push,
    input  csr_index_pkg::index_t    count,
    input  csr_index_pkg::addr_cfg_t addr_cfg,
    output csr_index_pkg::request_t  entry
);

    import csr_index_pkg::*;

    addr_t offset_comb;

    // Element size scaling, upper bits drop off on a left shift
    always_comb begin
        if (addr_cfg.shift_left) begin
            offset_comb = count << addr_cfg.shift_amount;
        end
        else begin
            offset_comb = count >> addr_cfg.shift_amount;
        end
    end

    // Valid doubles as the FIFO write strobe
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            entry.valid <= 1'b0;
        end
        else begin
            entry.valid <= push;
        end
    end

    always_ff @(posedge ap_clk) begin
        entry.payload.base   <= addr_cfg.base;
        entry.payload.offset <= offset_comb;
        entry.payload.index  <= count;
    end

endmodule : request_builder

`default_nettype wire

// ==== source/request_fifo.sv ====
// Show-ahead request FIFO; the oldest entry is always on the output, prog_full throttles the generator
`default_nettype none
`timescale 1ns/1ps

module request_fifo (
    input  logic                    ap_clk,
    input  logic                    areset_generator,
    input  csr_index_pkg::request_t entry,
    input  logic                    rd_en,
    output csr_index_pkg::request_t request,
    output logic                    prog_full
);

    import csr_index_pkg::*;

    request_payload_t                mem [FIFO_DEPTH];
    logic [$clog2(FIFO_DEPTH)-1:0]   wr_ptr;
    logic [$clog2(FIFO_DEPTH)-1:0]   rd_ptr;
    logic [FIFO_COUNT_W-1:0]         occupancy;
    logic                            do_write;
    logic                            do_read;

    assign do_write = entry.valid;
    // Pop on empty is dropped here
    assign do_read  = rd_en & (occupancy != '0);

    // ------------------------------
    // Storage
    // ------------------------------
    always_ff @(posedge ap_clk) begin
        if (do_write) begin
            mem[wr_ptr] <= entry.payload;
        end
    end

    // ------------------------------
    // Pointers and occupancy
    // ------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            occupancy <= '0;
        end
        else begin
            if (do_write) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_read) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_write, do_read})
                2'b10:   occupancy <= occupancy + 1'b1;
                2'b01:   occupancy <= occupancy - 1'b1;
                default: occupancy <= occupancy;
            endcase
        end
    end

    assign request.valid   = (occupancy != '0);
    assign request.payload = mem[rd_ptr];
    assign prog_full       = (occupancy >= FIFO_COUNT_W'(FIFO_PROG_THRESH));

endmodule : request_fifo

`default_nettype wire

// ==== src.f ====
source/csr_index_pkg.sv
source/index_counter.sv
source/index_gen_fsm.sv
source/request_builder.sv
source/request_fifo.sv
source/csr_index_generator.sv
verif/csr_index_generator_props.sv
verif/tb_csr_index_generator.sv

// ==== verif/csr_index_generator_props.sv ====
// Assertions bound into the request FIFO; they check occupancy limits and write safety in simulation
`default_nettype none
`timescale 1ns/1ps

module csr_index_generator_props (
    input logic                                   ap_clk,
    input logic                                   areset_generator,
    input logic                                   write_en,
    input logic [csr_index_pkg::FIFO_COUNT_W-1:0] occupancy,
    input logic                                   request_valid
);

    import csr_index_pkg::*;

    // A write into a full FIFO would overwrite the oldest entry
    no_write_when_full: assert property (@(posedge ap_clk) disable iff (areset_generator)
        !(write_en && (occupancy == FIFO_COUNT_W'(FIFO_DEPTH))))
        else $error("Request FIFO written while holding %0d entries", FIFO_DEPTH);

    occupancy_in_range: assert property (@(posedge ap_clk) disable iff (areset_generator)
        occupancy <= FIFO_COUNT_W'(FIFO_DEPTH))
        else $error("Request FIFO occupancy %0d is above its depth", occupancy);

    valid_known: assert property (@(posedge ap_clk) disable iff (areset_generator)
        !$isunknown(request_valid))
        else $error("Request valid is unknown after reset");

endmodule : csr_index_generator_props

bind request_fifo csr_index_generator_props i_props (
    .ap_clk           (ap_clk),
    .areset_generator (areset_generator),
    .write_en         (do_write),
    .occupancy        (occupancy),
    .request_valid    (request.valid)
);

`default_nettype wire

// ==== verif/tb_csr_index_generator.sv ====
// Table-driven testbench for the CSR index generator; runs each job row and checks every request
`default_nettype none
`timescale 1ns/1ps

module tb_csr_index_generator;

    import csr_index_pkg::*;

    localparam int NUM_ROWS    = 9;
    localparam int JOB_TIMEOUT = 20000;
    localparam logic [1:0] POP_ALWAYS = 2'd0;
    localparam logic [1:0] POP_HALF   = 2'd1;
    localparam logic [1:0] POP_RARE   = 2'd2;

    typedef struct packed {
        range_cfg_t range_cfg;
        addr_cfg_t  addr_cfg;
        logic [1:0] pop_class;
    } job_row_t;

    logic       ap_clk;
    logic       areset_generator;
    logic       start;
    logic       rd_en;
    logic       done;
    range_cfg_t range_cfg;
    addr_cfg_t  addr_cfg;
    request_t   request;

    job_row_t         job_table [NUM_ROWS];
    request_payload_t expected_q [$];

    csr_index_generator i_dut (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .start            (start),
        .range_cfg        (range_cfg),
        .addr_cfg         (addr_cfg),
        .rd_en            (rd_en),
        .request          (request),
        .done             (done)
    );

    always #4 ap_clk = ~ap_clk;

    // ------------------------------
    // Failure reporting
    // ------------------------------
    task automatic stop_on_failure();
        $display("TB FAILED");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check(input string name, input logic [63:0] expected,
                         input logic [63:0] actual);
        if (actual !== expected) begin
            $display("Fail at %0t: %s expected 0x%0h, actual 0x%0h",
                     $time, name, expected, actual);
            stop_on_failure();
        end
    endtask

    // ------------------------------
    // Reference model
    // ------------------------------
    // Index walk from start by stride while below the exclusive end
    task automatic build_expected(input job_row_t row);
        longint unsigned  idx;
        longint unsigned  scale;
        request_payload_t p;
        expected_q.delete();
        scale = 1;
        repeat (row.addr_cfg.shift_amount) begin
            scale = scale * 2;
        end
        idx = row.range_cfg.index_start;
        while (idx < row.range_cfg.index_end) begin
            p.base  = row.addr_cfg.base;
            p.index = idx[INDEX_W-1:0];
            if (row.addr_cfg.shift_left) begin
                // Scaled by a power of two and cut to the address width
                p.offset = addr_t'(idx * scale);
            end
            else begin
                p.offset = addr_t'(idx / scale);
            end
            expected_q.push_back(p);
            idx = idx + row.range_cfg.stride;
        end
    endtask

    function automatic logic pick_rd_en(input logic [1:0] pop_class);
        logic pop;
        case (pop_class)
            POP_ALWAYS: pop = 1'b1;
            POP_HALF:   pop = (($urandom % 2) == 0);
            default:    pop = (($urandom % 8) == 0);
        endcase
        return pop;
    endfunction

    // ------------------------------
    // Job sequencing
    // ------------------------------
    task automatic start_job(input job_row_t row);
        @(posedge ap_clk);
        #1;
        // A second done pulse of the previous job would show up here
        check("done", 0, done);
        range_cfg = row.range_cfg;
        addr_cfg  = row.addr_cfg;
        rd_en     = 1'b0;
        start     = 1'b1;
        @(posedge ap_clk);
        #1;
        check("done", 0, done);
        start = 1'b0;
    endtask

    task automatic run_job(input int row);
        job_row_t         cfg_row;
        request_payload_t exp_p;
        int               expected_total;
        int               got;
        int               done_count;
        int               cycles;
        logic             finished;
        logic             saw_full;
        cfg_row = job_table[row];
        build_expected(cfg_row);
        expected_total = expected_q.size();
        got        = 0;
        done_count = 0;
        cycles     = 0;
        finished   = 1'b0;
        saw_full   = 1'b0;
        start_job(cfg_row);
        while (!finished) begin
            @(posedge ap_clk);
            #1;
            if (done) begin
                done_count++;
            end
            if (i_dut.prog_full) begin
                saw_full = 1'b1;
            end
            // Finished once the job is done and nothing is left to pop
            if (done_count > 0 && !request.valid) begin
                finished = 1'b1;
                rd_en    = 1'b0;
            end
            else begin
                rd_en = pick_rd_en(cfg_row.pop_class);
                // Shown entry leaves the FIFO on the coming edge
                if (rd_en && request.valid) begin
                    if (expected_q.size() == 0) begin
                        check("requests in job", expected_total, got + 1);
                    end
                    exp_p = expected_q.pop_front();
                    check("request.payload.index", exp_p.index, request.payload.index);
                    check("request.payload.base", exp_p.base, request.payload.base);
                    check("request.payload.offset", exp_p.offset, request.payload.offset);
                    got++;
                end
                cycles++;
                if (cycles > JOB_TIMEOUT) begin
                    $display("Timeout: job %0d did not finish within %0d cycles",
                             row, JOB_TIMEOUT);
                    stop_on_failure();
                end
            end
        end
        check("requests in job", expected_total, got);
        check("done pulses in job", 1, done_count);
        if (cfg_row.pop_class == POP_RARE && expected_total > FIFO_DEPTH) begin
            check("prog_full seen", 1, saw_full);
        end
    endtask

    // ------------------------------
    // Main sequence
    // ------------------------------
    initial begin
        ap_clk           = 1'b0;
        areset_generator = 1'b1;
        start            = 1'b0;
        rd_en            = 1'b0;
        range_cfg        = '0;
        addr_cfg         = '0;
        void'($urandom(32'h4780));

        // start, end, stride / base, shift amount, shift left / pop class
        job_table[0] = '{'{32'd0, 32'd10, 32'd1}, '{32'h1000_0000, 5'd2, 1'b1}, POP_ALWAYS};
        job_table[1] = '{'{32'd100, 32'd120, 32'd1}, '{32'h2000_0000, 5'd3, 1'b0}, POP_HALF};
        job_table[2] = '{'{32'd7, 32'd40, 32'd5}, '{32'h3000_0040, 5'd4, 1'b1}, POP_HALF};
        job_table[3] = '{'{32'd50, 32'd50, 32'd1}, '{32'h0000_8000, 5'd0, 1'b1}, POP_ALWAYS};
        job_table[4] = '{'{32'd60, 32'd20, 32'd2}, '{32'h0000_9000, 5'd1, 1'b0}, POP_HALF};
        job_table[5] = '{'{32'd5, 32'd305, 32'd3}, '{32'h4000_0000, 5'd3, 1'b1}, POP_RARE};
        job_table[6] = '{'{32'h8000_0010, 32'h8000_0030, 32'd4},
                         '{32'h5000_0000, 5'd31, 1'b0}, POP_HALF};
        // Left shift by 8 drops the upper index bits
        job_table[7] = '{'{32'h0F00_0001, 32'h0F00_0010, 32'd1},
                         '{32'h6000_0000, 5'd8, 1'b1}, POP_ALWAYS};
        job_table[8] = '{'{32'd0, 32'd200, 32'd1}, '{32'h7000_0000, 5'd1, 1'b0}, POP_RARE};

        repeat (4) @(posedge ap_clk);
        #1;
        areset_generator = 1'b0;

        // Idle after reset
        repeat (3) begin
            @(posedge ap_clk);
            #1;
            check("request.valid", 0, request.valid);
            check("done", 0, done);
        end

        for (int row = 0; row < NUM_ROWS; row++) begin
            run_job(row);
        end

        // No stray pulse or request once all jobs are over
        repeat (5) begin
            @(posedge ap_clk);
            #1;
            check("request.valid", 0, request.valid);
            check("done", 0, done);
        end

        $display("TB PASSED");
        $finish;
    end

endmodule : tb_csr_index_generator

`default_nettype wire
